// File: bench/tge_eth_checker.sv
`timescale 1ns/10ps

module tge_eth_checker import tge_pkg::*; (
  input logic      clk,
  input logic      mac_resetRR,
  input logic      mac_tx_valid,
  input logic      mac_tx_ready,
  input tge_word_t mac_tx_data,
  input logic      mac_tx_last,
  input logic      rx_valid,
  input logic      rx_end_of_frame,
  input logic      rx_bad_frame,
  input logic      tx_overflow,
  input logic      led_up,
  input logic      led_rx,
  input logic      led_tx
);

  // MAC side must hold the beat until it is taken
  tx_hold: assert property (@(posedge clk) disable iff (mac_resetRR)
    mac_tx_valid && !mac_tx_ready |=>
      mac_tx_valid && $stable(mac_tx_data) && $stable(mac_tx_last))
    else $error("mac_tx beat changed or dropped while ready was low");

  rx_eof_valid: assert property (@(posedge clk) disable iff (mac_resetRR)
    rx_end_of_frame |-> rx_valid)
    else $error("rx_end_of_frame seen without rx_valid");

  rx_bad_eof: assert property (@(posedge clk) disable iff (mac_resetRR)
    rx_bad_frame |-> rx_end_of_frame)
    else $error("rx_bad_frame seen without rx_end_of_frame");

  // Control outputs quiet right after a reset cycle
  reset_quiet: assert property (@(posedge clk)
    mac_resetRR |=> !mac_tx_valid && !rx_valid && !rx_end_of_frame &&
      !rx_bad_frame && !tx_overflow && !led_up && !led_rx && !led_tx)
    else $error("control output high in the cycle after reset");

endmodule

// File: bench/tge_eth_tb.sv
`timescale 1ns/10ps
`include "tge_config.svh"

module tge_eth_tb import tge_pkg::*; ();

  localparam tge_ip_t   LOCAL_IP   = 32'h0a00_0001;
  localparam tge_port_t LOCAL_PORT = 16'd5000;
  localparam int        LED_CYCLES = 1 << (`TGE_LED_BITS - 1);
  localparam int        BIG_FRAME  = (1 << `TGE_TX_FIFO_AW) + 8;

  logic clk, mac_resetRR, local_enable, link_up;
  logic tx_valid, tx_end_of_frame, tx_overflow, tx_afull;
  tge_word_t tx_data, mac_tx_data, mac_rx_data, rx_data;
  tge_ip_t tx_dest_ip, rx_source_ip, local_ip;
  tge_port_t tx_dest_port, rx_source_port, local_port;
  logic mac_tx_valid, mac_tx_last, mac_tx_ready;
  logic mac_rx_valid, mac_rx_last, mac_rx_bad;
  logic rx_valid, rx_end_of_frame, rx_bad_frame;
  logic led_up, led_rx, led_tx;

  logic [15:0] lfsr = 16'd64;
  int          ready_mode, errors, timeouts, frames_rx;
  string       test_name;
  tge_word_t   exp_data [$];
  bit          exp_last [$];
  bit          exp_bad [$];
  bit          mark_q [$];
  int          len_q [$];
  bit          fwd_valid, fwd_last, prev_tx_start, prev_rx_good;
  bit          tx_start_now, rx_good_now;
  bit          afull_seen, ovf_seen, rx_led_seen;
  tge_word_t   fwd_data, want;
  tge_count_t  want_count;
  int          tx_run, rx_run, last_tx_len, last_rx_len;
  int          tx_beat;

  tge_eth uut (.*);

  bind tge_eth tge_eth_checker checker_inst (
    .clk(clk), .mac_resetRR(mac_resetRR), .mac_tx_valid(mac_tx_valid),
    .mac_tx_ready(mac_tx_ready), .mac_tx_data(mac_tx_data),
    .mac_tx_last(mac_tx_last), .rx_valid(rx_valid),
    .rx_end_of_frame(rx_end_of_frame), .rx_bad_frame(rx_bad_frame),
    .tx_overflow(tx_overflow), .led_up(led_up), .led_rx(led_rx), .led_tx(led_tx)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Galois LFSR, one step per bit taken
  function automatic tge_word_t next_bits(input int n);
    tge_word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
    end
    return v;
  endfunction

  always begin
    @(posedge clk);
    #2;
    mac_tx_ready = (ready_mode == 0) || (ready_mode == 1 && next_bits(2) != 0);
  end

  // Loopback MAC, forwards each accepted tx beat one cycle later
  always begin
    @(negedge clk);
    fwd_valid = mac_tx_valid && mac_tx_ready;
    fwd_data = mac_tx_data;
    fwd_last = mac_tx_last;
    @(posedge clk);
    #2;
    mac_rx_valid = fwd_valid;
    mac_rx_data = fwd_data;
    mac_rx_last = fwd_valid && fwd_last;
    mac_rx_bad = 1'b0;
    if (fwd_valid && fwd_last && mark_q.size() != 0) begin
      mac_rx_bad = mark_q.pop_front();
    end
  end

  // Scoreboard and LED monitor
  always @(negedge clk) begin
    if (!mac_resetRR) begin
      tx_start_now = 1'b0;
      rx_good_now = 1'b0;
      if (mac_tx_valid && mac_tx_ready) begin
        // Beat 0 is header word 0, beat 1 carries the word count
        tx_start_now = tx_beat == 0;
        if (tx_beat == 1) begin
          assert (len_q.size() != 0) else begin
            errors++;
            $display("%s: header sent for a frame that was never committed", test_name);
          end
          if (len_q.size() != 0) begin
            want_count = tge_count_t'(len_q.pop_front());
            assert (mac_tx_data[15:0] == want_count) else begin
              errors++;
              $display("[ERROR] %s header count: expected %0d, actual %0d",
                       test_name, want_count, mac_tx_data[15:0]);
            end
          end
        end
        tx_beat = mac_tx_last ? 0 : tx_beat + 1;
      end
      if (rx_valid) begin
        assert (exp_data.size() != 0) else begin
          errors++;
          $display("%s: rx_valid with no frame outstanding", test_name);
        end
        if (exp_data.size() != 0) begin
          want = exp_data.pop_front();
          assert (rx_data == want) else begin
            errors++;
            $display("[ERROR] %s rx_data: expected %h, actual %h", test_name, want, rx_data);
          end
          assert (rx_end_of_frame == exp_last[0]) else begin
            errors++;
            $display("[ERROR] %s rx_end_of_frame: expected %0d, actual %0d",
                     test_name, exp_last[0], rx_end_of_frame);
          end
          assert (rx_bad_frame == (exp_last[0] && exp_bad[0])) else begin
            errors++;
            $display("[ERROR] %s rx_bad_frame: expected %0d, actual %0d",
                     test_name, exp_last[0] && exp_bad[0], rx_bad_frame);
          end
          assert (rx_source_ip == LOCAL_IP && rx_source_port == LOCAL_PORT) else begin
            errors++;
            $display("[ERROR] %s rx_source: expected %h:%h, actual %h:%h", test_name,
                     LOCAL_IP, LOCAL_PORT, rx_source_ip, rx_source_port);
          end
          rx_good_now = exp_last[0] && !exp_bad[0];
          frames_rx += int'(rx_end_of_frame);
          void'(exp_last.pop_front());
          void'(exp_bad.pop_front());
        end
      end
      assert (!prev_tx_start || led_tx) else begin
        errors++;
        $display("[ERROR] %s led_tx after start: expected 1, actual 0", test_name);
      end
      assert (!prev_rx_good || led_rx) else begin
        errors++;
        $display("[ERROR] %s led_rx after good frame: expected 1, actual 0", test_name);
      end
      assert (!tx_overflow || afull_seen) else begin
        errors++;
        $display("%s: tx_overflow rose before tx_afull", test_name);
      end
      prev_tx_start = tx_start_now;
      prev_rx_good = rx_good_now;
      afull_seen |= tx_afull;
      ovf_seen |= tx_overflow;
      rx_led_seen |= led_rx;
      if (led_tx) tx_run++;
      else if (tx_run != 0) begin
        last_tx_len = tx_run;
        tx_run = 0;
      end
      if (led_rx) rx_run++;
      else if (rx_run != 0) begin
        last_rx_len = rx_run;
        rx_run = 0;
      end
    end
  end

  task automatic send_frame(input int len, input tge_ip_t ip, input tge_port_t port,
                            input bit deliver, input bit bad, input bit commits);
    tge_word_t w;
    if (commits) begin
      mark_q.push_back(bad);
      len_q.push_back(len);
    end
    for (int i = 0; i < len; i++) begin
      w = next_bits(64);
      @(posedge clk);
      #2;
      tx_valid = 1'b1;
      tx_data = w;
      tx_end_of_frame = (i == len - 1);
      tx_dest_ip = ip;
      tx_dest_port = port;
      if (commits && deliver) begin
        exp_data.push_back(w);
        exp_last.push_back(i == len - 1);
        exp_bad.push_back(bad);
      end
    end
    @(posedge clk);
    #2;
    tx_valid = 1'b0;
    tx_end_of_frame = 1'b0;
  endtask

  task automatic wait_drain(input string what);
    int quiet;
    int n;
    quiet = 0;
    n = 0;
    while (quiet < 4 && n < 2000) begin
      @(negedge clk);
      n++;
      if (exp_data.size() == 0 && !mac_tx_valid && !mac_rx_valid) quiet++;
      else quiet = 0;
    end
    if (quiet < 4) begin
      timeouts++;
      $display("Timeout: %s did not drain within 2000 cycles", what);
    end
  endtask

  task automatic wait_leds_off();
    int n;
    n = 0;
    while ((led_tx || led_rx) && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (led_tx || led_rx) begin
      timeouts++;
      $display("Timeout: activity LEDs stayed lit for 100 cycles");
    end
    // Let the monitor finish the falling edge it just saw
    @(posedge clk);
  endtask

  task automatic rand_frame(input bit bad);
    send_frame(1 + int'(next_bits(3)) % 6, LOCAL_IP, LOCAL_PORT, 1'b1, bad, 1'b1);
  endtask

  initial begin
    int n;
    mac_resetRR = 1'b1;
    local_enable = 1'b1;
    local_ip = LOCAL_IP;
    local_port = LOCAL_PORT;
    link_up = 1'b1;
    tx_valid = 1'b0;
    tx_end_of_frame = 1'b0;
    tx_data = '0;
    tx_dest_ip = '0;
    tx_dest_port = '0;
    mac_tx_ready = 1'b1;
    mac_rx_valid = 1'b0;
    mac_rx_data = '0;
    mac_rx_last = 1'b0;
    mac_rx_bad = 1'b0;
    test_name = "reset";
    repeat (2) @(posedge clk);
    #2;
    mac_resetRR = 1'b0;

    test_name = "loopback";
    repeat (3) rand_frame(1'b0);
    wait_drain(test_name);

    test_name = "filtering";
    send_frame(3, LOCAL_IP ^ 32'h1, LOCAL_PORT, 1'b0, 1'b0, 1'b1);
    send_frame(2, LOCAL_IP, LOCAL_PORT + 16'd1, 1'b0, 1'b0, 1'b1);
    rand_frame(1'b0);
    wait_drain(test_name);

    test_name = "backpressure";
    ready_mode = 1;
    repeat (5) rand_frame(1'b0);
    wait_drain(test_name);
    ready_mode = 0;

    test_name = "overflow";
    ready_mode = 2;
    afull_seen = 1'b0;
    ovf_seen = 1'b0;
    send_frame(4, LOCAL_IP, LOCAL_PORT, 1'b1, 1'b0, 1'b1);
    send_frame(BIG_FRAME, LOCAL_IP, LOCAL_PORT, 1'b1, 1'b0, 1'b0);
    assert (afull_seen && ovf_seen) else begin
      errors++;
      $display("[ERROR] %s afull/overflow seen: expected 11, actual %0d%0d",
               test_name, afull_seen, ovf_seen);
    end
    ready_mode = 0;
    rand_frame(1'b0);
    wait_drain(test_name);

    test_name = "bad_frame";
    wait_leds_off();
    rx_led_seen = 1'b0;
    send_frame(3, LOCAL_IP, LOCAL_PORT, 1'b1, 1'b1, 1'b1);
    wait_drain(test_name);
    assert (!rx_led_seen) else begin
      errors++;
      $display("[ERROR] %s led_rx: expected 0, actual 1", test_name);
    end

    test_name = "leds";
    wait_leds_off();
    last_tx_len = 0;
    last_rx_len = 0;
    rand_frame(1'b0);
    wait_drain(test_name);
    wait_leds_off();
    assert (last_tx_len == LED_CYCLES && last_rx_len == LED_CYCLES) else begin
      errors++;
      $display("[ERROR] %s stretch tx/rx: expected %0d, actual %0d/%0d",
               test_name, LED_CYCLES, last_tx_len, last_rx_len);
    end
    @(posedge clk);
    #2;
    link_up = 1'b0;
    @(posedge clk);
    #1;
    assert (!led_up) else begin
      errors++;
      $display("[ERROR] %s led_up while down: expected 0, actual 1", test_name);
    end
    #1;
    link_up = 1'b1;
    n = 0;
    while (!led_up && n < 100) begin
      @(posedge clk);
      #1;
      n++;
    end
    assert (n == LED_CYCLES) else begin
      errors++;
      $display("[ERROR] %s led_up return: expected %0d, actual %0d", test_name, LED_CYCLES, n);
    end

    $display("Done: %0d errors, %0d timeouts, %0d frames received", errors, timeouts, frames_rx);
    if (errors == 0 && timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: hdl/tge_activity.sv
`timescale 1ns/10ps
`include "tge_config.svh"

module tge_activity (
  input  logic clk,
  input  logic mac_resetRR,
  input  logic tx_frame_start,
  input  logic rx_frame_good,
  input  logic link_up,
  output logic led_up,
  output logic led_rx,
  output logic led_tx
);

  localparam int LB = `TGE_LED_BITS;

  // Index 0 is link down, 1 is rx, 2 is tx
  logic [LB-1:0] stretch [3];
  logic [2:0]    trig;
  logic          link_seen;

  assign trig = {tx_frame_start, rx_frame_good, !link_up};

  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      for (int i = 0; i < 3; i++) begin
        stretch[i] <= '0;
      end
      link_seen <= 1'b0;
    end else begin
      link_seen <= link_up;
      for (int i = 0; i < 3; i++) begin
        if (trig[i]) begin
          stretch[i] <= '1;
        end else if (stretch[i][LB-1]) begin
          stretch[i] <= stretch[i] - 1'b1;
        end
      end
    end
  end

  // Up only once link has been seen and the down stretch has run out
  assign led_up = link_seen && !stretch[0][LB-1];
  assign led_rx = stretch[1][LB-1];
  assign led_tx = stretch[2][LB-1];

endmodule

// File: hdl/tge_config.svh
`ifndef TGE_CONFIG_SVH
`define TGE_CONFIG_SVH

// Transmit FIFO address width, 32 words by default
`define TGE_TX_FIFO_AW 5

// Almost-full once free space drops to this many words
`define TGE_TX_AFULL_MARGIN 4

// Stretch counter width, LED lit for 2**(bits-1) cycles
`define TGE_LED_BITS 4

`endif

// File: hdl/tge_eth.sv
`timescale 1ns/10ps

module tge_eth import tge_pkg::*; (
  input  logic      clk,
  input  logic      mac_resetRR,
  input  logic      local_enable,
  input  tge_ip_t   local_ip,
  input  tge_port_t local_port,
  input  logic      tx_valid,
  input  logic      tx_end_of_frame,
  input  tge_word_t tx_data,
  input  tge_ip_t   tx_dest_ip,
  input  tge_port_t tx_dest_port,
  output logic      tx_overflow,
  output logic      tx_afull,
  output logic      mac_tx_valid,
  output tge_word_t mac_tx_data,
  output logic      mac_tx_last,
  input  logic      mac_tx_ready,
  input  logic      mac_rx_valid,
  input  tge_word_t mac_rx_data,
  input  logic      mac_rx_last,
  input  logic      mac_rx_bad,
  output logic      rx_valid,
  output logic      rx_end_of_frame,
  output tge_word_t rx_data,
  output tge_ip_t   rx_source_ip,
  output tge_port_t rx_source_port,
  output logic      rx_bad_frame,
  input  logic      link_up,
  output logic      led_up,
  output logic      led_rx,
  output logic      led_tx
);

  logic tx_frame_start;
  logic rx_frame_good;

  tge_tx tge_tx_inst (
    .clk             (clk),
    .mac_resetRR     (mac_resetRR),
    .local_enable    (local_enable),
    .local_ip        (local_ip),
    .local_port      (local_port),
    .tx_valid        (tx_valid),
    .tx_end_of_frame (tx_end_of_frame),
    .tx_data         (tx_data),
    .tx_dest_ip      (tx_dest_ip),
    .tx_dest_port    (tx_dest_port),
    .tx_overflow     (tx_overflow),
    .tx_afull        (tx_afull),
    .mac_tx_valid    (mac_tx_valid),
    .mac_tx_data     (mac_tx_data),
    .mac_tx_last     (mac_tx_last),
    .mac_tx_ready    (mac_tx_ready),
    .tx_frame_start  (tx_frame_start)
  );

  tge_rx tge_rx_inst (
    .clk             (clk),
    .mac_resetRR     (mac_resetRR),
    .local_enable    (local_enable),
    .local_ip        (local_ip),
    .local_port      (local_port),
    .mac_rx_valid    (mac_rx_valid),
    .mac_rx_data     (mac_rx_data),
    .mac_rx_last     (mac_rx_last),
    .mac_rx_bad      (mac_rx_bad),
    .rx_valid        (rx_valid),
    .rx_end_of_frame (rx_end_of_frame),
    .rx_data         (rx_data),
    .rx_source_ip    (rx_source_ip),
    .rx_source_port  (rx_source_port),
    .rx_bad_frame    (rx_bad_frame),
    .rx_frame_good   (rx_frame_good)
  );

  tge_activity tge_activity_inst (
    .clk            (clk),
    .mac_resetRR    (mac_resetRR),
    .tx_frame_start (tx_frame_start),
    .rx_frame_good  (rx_frame_good),
    .link_up        (link_up),
    .led_up         (led_up),
    .led_rx         (led_rx),
    .led_tx         (led_tx)
  );

endmodule

// File: hdl/tge_pkg.sv
package tge_pkg;

  // Payload and header word
  typedef logic [63:0] tge_word_t;

  // IPv4 address
  typedef logic [31:0] tge_ip_t;

  // UDP port
  typedef logic [15:0] tge_port_t;

  // Payload length in words, carried in header word 1
  typedef logic [15:0] tge_count_t;

  typedef enum logic [1:0] {
    tx_idle,
    tx_head0,
    tx_head1,
    tx_payload
  } tge_tx_state_t;

  typedef enum logic [1:0] {
    rx_head0,
    rx_head1,
    rx_deliver,
    rx_discard
  } tge_rx_state_t;

endpackage

// File: hdl/tge_rx.sv
`timescale 1ns/10ps

module tge_rx import tge_pkg::*; (
  input  logic      clk,
  input  logic      mac_resetRR,
  input  logic      local_enable,
  input  tge_ip_t   local_ip,
  input  tge_port_t local_port,
  input  logic      mac_rx_valid,
  input  tge_word_t mac_rx_data,
  input  logic      mac_rx_last,
  input  logic      mac_rx_bad,
  output logic      rx_valid,
  output logic      rx_end_of_frame,
  output tge_word_t rx_data,
  output tge_ip_t   rx_source_ip,
  output tge_port_t rx_source_port,
  output logic      rx_bad_frame,
  output logic      rx_frame_good
);

  tge_rx_state_t state;
  tge_ip_t       hdr_src_ip;
  tge_ip_t       hdr_dst_ip;
  logic          match;
  logic          beat_out;

  // Header word 1 is on the bus when this is evaluated
  assign match = local_enable && hdr_dst_ip == local_ip &&
                 mac_rx_data[47:32] == local_port;

  assign beat_out = state == rx_deliver && mac_rx_valid;

  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      state <= rx_head0;
    end else if (mac_rx_valid) begin
      case (state)
        rx_head0: begin
          if (!mac_rx_last) begin
            state <= rx_head1;
          end
        end
        rx_head1: begin
          if (mac_rx_last) begin
            state <= rx_head0;
          end else if (match) begin
            state <= rx_deliver;
          end else begin
            state <= rx_discard;
          end
        end
        default: begin
          if (mac_rx_last) begin
            state <= rx_head0;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      rx_valid        <= 1'b0;
      rx_end_of_frame <= 1'b0;
      rx_bad_frame    <= 1'b0;
      rx_frame_good   <= 1'b0;
    end else begin
      rx_valid        <= beat_out;
      rx_end_of_frame <= beat_out && mac_rx_last;
      rx_bad_frame    <= beat_out && mac_rx_last && mac_rx_bad;
      rx_frame_good   <= beat_out && mac_rx_last && !mac_rx_bad;
    end
  end

  always_ff @(posedge clk) begin
    if (state == rx_head0 && mac_rx_valid) begin
      hdr_src_ip <= mac_rx_data[63:32];
      hdr_dst_ip <= mac_rx_data[31:0];
    end
    // Source only updates on acceptance, so it stays put across the frame
    if (state == rx_head1 && mac_rx_valid && match) begin
      rx_source_ip   <= hdr_src_ip;
      rx_source_port <= mac_rx_data[63:48];
    end
    if (beat_out) begin
      rx_data <= mac_rx_data;
    end
  end

endmodule

// File: hdl/tge_tx.sv
`timescale 1ns/10ps
`include "tge_config.svh"

module tge_tx import tge_pkg::*; (
  input  logic       clk,
  input  logic       mac_resetRR,
  input  logic       local_enable,
  input  tge_ip_t    local_ip,
  input  tge_port_t  local_port,
  input  logic       tx_valid,
  input  logic       tx_end_of_frame,
  input  tge_word_t  tx_data,
  input  tge_ip_t    tx_dest_ip,
  input  tge_port_t  tx_dest_port,
  output logic       tx_overflow,
  output logic       tx_afull,
  output logic       mac_tx_valid,
  output tge_word_t  mac_tx_data,
  output logic       mac_tx_last,
  input  logic       mac_tx_ready,
  output logic       tx_frame_start
);

  localparam int AW    = `TGE_TX_FIFO_AW;
  localparam int DEPTH = 1 << AW;

  typedef logic [AW:0] ptr_t;

  tge_word_t     mem [DEPTH];
  // Committed frame queue, never fuller than the word FIFO
  tge_ip_t       q_ip [DEPTH];
  tge_port_t     q_port [DEPTH];
  tge_count_t    q_count [DEPTH];

  ptr_t          wr_ptr;
  ptr_t          commit_ptr;
  ptr_t          rd_ptr;
  ptr_t          q_wr;
  ptr_t          q_rd;
  ptr_t          used;
  ptr_t          frame_len;
  logic          accept;
  logic          ovf_now;
  logic          wr_en;
  logic          commit;
  logic          dropping;
  logic          q_empty;
  tge_tx_state_t state;
  tge_ip_t       hdr_ip;
  tge_port_t     hdr_port;
  tge_count_t    hdr_count;

  assign used      = wr_ptr - rd_ptr;
  assign accept    = local_enable && tx_valid;
  assign ovf_now   = accept && used[AW];
  assign wr_en     = accept && !used[AW] && !dropping;
  assign commit    = wr_en && tx_end_of_frame;
  assign frame_len = wr_ptr - commit_ptr + 1'b1;
  assign q_empty   = q_wr == q_rd;
  assign tx_afull  = used >= ptr_t'(DEPTH - `TGE_TX_AFULL_MARGIN);

  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      wr_ptr      <= '0;
      commit_ptr  <= '0;
      q_wr        <= '0;
      dropping    <= 1'b0;
      tx_overflow <= 1'b0;
    end else begin
      tx_overflow <= ovf_now;
      if (commit) begin
        wr_ptr     <= wr_ptr + 1'b1;
        commit_ptr <= wr_ptr + 1'b1;
        q_wr       <= q_wr + 1'b1;
      end else if (accept && tx_end_of_frame) begin
        // Overflowed frame, roll back to its first word
        wr_ptr   <= commit_ptr;
        dropping <= 1'b0;
      end else begin
        if (wr_en) begin
          wr_ptr <= wr_ptr + 1'b1;
        end
        if (ovf_now) begin
          dropping <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[AW-1:0]] <= tx_data;
    end
    if (commit) begin
      q_ip[q_wr[AW-1:0]]    <= tx_dest_ip;
      q_port[q_wr[AW-1:0]]  <= tx_dest_port;
      q_count[q_wr[AW-1:0]] <= tge_count_t'(frame_len);
    end
  end

  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      state  <= tx_idle;
      rd_ptr <= '0;
      q_rd   <= '0;
    end else begin
      case (state)
        tx_idle: begin
          if (!q_empty) begin
            q_rd  <= q_rd + 1'b1;
            state <= tx_head0;
          end
        end
        tx_head0: begin
          if (mac_tx_ready) begin
            state <= tx_head1;
          end
        end
        tx_head1: begin
          if (mac_tx_ready) begin
            state <= tx_payload;
          end
        end
        default: begin
          if (mac_tx_ready) begin
            rd_ptr <= rd_ptr + 1'b1;
            if (mac_tx_last) begin
              state <= tx_idle;
            end
          end
        end
      endcase
    end
  end

  // hdr_count doubles as the remaining word count once payload starts
  always_ff @(posedge clk) begin
    if (state == tx_idle && !q_empty) begin
      hdr_ip    <= q_ip[q_rd[AW-1:0]];
      hdr_port  <= q_port[q_rd[AW-1:0]];
      hdr_count <= q_count[q_rd[AW-1:0]];
    end else if (state == tx_payload && mac_tx_ready) begin
      hdr_count <= hdr_count - 1'b1;
    end
  end

  assign mac_tx_valid   = state != tx_idle;
  assign mac_tx_last    = state == tx_payload && hdr_count == tge_count_t'(1);
  assign tx_frame_start = state == tx_head0 && mac_tx_ready;

  always_comb begin
    case (state)
      tx_head0:   mac_tx_data = {local_ip, hdr_ip};
      tx_head1:   mac_tx_data = {local_port, hdr_port, 16'h0000, hdr_count};
      tx_payload: mac_tx_data = mem[rd_ptr[AW-1:0]];
      default:    mac_tx_data = '0;
    endcase
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the tge_eth testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tge_eth_tb \
  -f sources.f -o sim_tge_eth

./obj_dir/sim_tge_eth > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0

// File: sources.f
+incdir+hdl
hdl/tge_pkg.sv
hdl/tge_tx.sv
hdl/tge_rx.sv
hdl/tge_activity.sv
hdl/tge_eth.sv
bench/tge_eth_checker.sv
bench/tge_eth_tb.sv
